/* compile.f */
logic/demodPkg.sv
logic/demodRegs.sv
logic/magFilter.sv
logic/falseLockDetector.sv
logic/dacMux.sv
logic/demodMonitor.sv
verification/demodMonitorTb.sv

/* Makefile */
TOP := demodMonitorTb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/demodMonitorTb.sv */
`timescale 1ns/1ps

module demodMonitorTb;
    import demodPkg::*;

    // sample slots of all bursts, and an upper bound on register transactions
    localparam int SampleCount    = 7 * 16 + 2 * 64 + 2 * 80;
    localparam int AxiCount       = 60;
    localparam int WatchdogCycles = (SampleCount + AxiCount) * 20;

    logic       clk;
    logic       rstN;
    regAddr_t   awaddr;
    logic       awvalid;
    logic       awready;
    regData_t   wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    regAddr_t   araddr;
    logic       arvalid;
    logic       arready;
    regData_t   rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;
    logic       sampleValid;
    sample_t    iIn;
    sample_t    qIn;
    freqWord_t  freq;
    freqWord_t  freqError;
    mag_t       mag;
    sample_t    dac0Data;
    logic       dac0Strobe;
    sample_t    dac1Data;
    logic       dac1Strobe;
    sample_t    dac2Data;
    logic       dac2Strobe;
    logic       highFreqOffset;

    // reference state
    magAccum_t   modelAccum = '0;
    sample_t     modelAvg = '0;
    sample_t     modelFreqSample = '0;
    sample_t     expDac [3];
    logic        expStrobe = 1'b0;
    logic        expHigh = 1'b0;
    regData_t    shadowCtrl = '0;
    regData_t    shadowFl = '0;
    regData_t    shadowDac = '0;
    logic [31:0] rngState = 32'hb28;

    demodMonitor demodMonitor_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic regData_t mergeBytes(regData_t old, regData_t data, logic [3:0] strb);
        regData_t mask;
        for (int b = 0; b < 4; b++) begin
            mask[b*8 +: 8] = {8{strb[b]}};
        end
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic regData_t expectedReadData(regAddr_t addr);
        case (addr)
            CtrlOffset:      return shadowCtrl;
            FalseLockOffset: return shadowFl;
            DacSelectOffset: return shadowDac;
            StatusOffset:    return {31'b0, expHigh};
            default:         return '0;
        endcase
    endfunction

    // lag loop, accumulator settles at mag * 2^22
    function automatic magAccum_t magLoopModel(magAccum_t acc, mag_t m, logic [3:0] tc);
        logic signed [9:0] err;
        magAccum_t         ext;
        err = 10'({1'b0, m}) - 10'(acc[31:22]);
        ext = 32'(err);
        return acc + (ext << (MagShiftBase - 32'(tc)));
    endfunction

    function automatic sample_t averagerModel(sample_t avg, sample_t smp, logic [15:0] alpha);
        logic signed [17:0] gain;
        logic signed [17:0] keep;
        logic signed [35:0] total;
        gain  = {alpha, 2'b00};
        keep  = 18'h20000 + ~gain;
        total = smp * gain + avg * keep;
        return total[34:17];
    endfunction

    function automatic logic [17:0] absValue(sample_t v);
        return v[17] ? 18'(-v) : 18'(v);
    endfunction

    function automatic sample_t dacSourceModel(logic [3:0] sel, magAccum_t acc, sample_t avg);
        case (sel)
            DacQ:         return qIn;
            DacFreq:      return {freq, 10'b0};
            DacFreqError: return {freqError, 10'b0};
            DacMag:       return {~acc[31], acc[30:14]};
            DacAvgFreq:   return avg;
            default:      return iIn;
        endcase
    endfunction

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkSample(string name, sample_t expVal, sample_t actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("[FAIL] %0t ns %s expected %h got %h", $time, name, expVal, actVal));
        end
    endtask

    task automatic checkRegData(string name, regData_t expVal, regData_t actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("[FAIL] %0t ns %s expected %h got %h", $time, name, expVal, actVal));
        end
    endtask

    task automatic checkBit(string name, logic expVal, logic actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("[FAIL] %0t ns %s expected %b got %b", $time, name, expVal, actVal));
        end
    endtask

    task automatic writeReg(regAddr_t addr, regData_t data, logic [3:0] strb, logic holdResp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = !holdResp;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        checkRegData("bresp", '0, regData_t'(bresp));
        case (addr)
            CtrlOffset:      shadowCtrl = mergeBytes(shadowCtrl, data, strb);
            FalseLockOffset: shadowFl   = mergeBytes(shadowFl, data, strb);
            DacSelectOffset: shadowDac  = mergeBytes(shadowDac, data, strb);
            default: ;
        endcase
    endtask

    task automatic expectRead(regAddr_t addr);
        regData_t expected;
        expected = expectedReadData(addr);
        @(negedge clk);
        // no read pending, so the address channel is open
        checkBit("arready", 1'b1, arready);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        arvalid = 1'b0;
        checkBit("arready", 1'b0, arready);
        checkRegData("rresp", '0, regData_t'(rresp));
        checkRegData($sformatf("rdata at %h", addr), expected, rdata);
    endtask

    // random idle cycles between samples, back to back otherwise
    task automatic sendSamples(int count, logic fixMag, mag_t magValue,
                               logic fixFreq, freqWord_t freqValue);
        int          sent;
        logic [31:0] r1;
        logic [31:0] r2;
        sent = 0;
        while (sent < count) begin
            @(negedge clk);
            r1 = lcgNext();
            r2 = lcgNext();
            sampleValid = (r1[13:11] != 3'd0);
            iIn         = r1[31:14];
            qIn         = r2[31:14];
            freq        = fixFreq ? freqValue : r1[10:3];
            freqError   = fixFreq ? freqWord_t'(-freqValue) : r2[10:3];
            mag         = fixMag ? magValue : r2[8:0];
            if (sampleValid) begin
                sent++;
            end
        end
        @(negedge clk);
        sampleValid = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // model steps on the same edge as the DUT
    always @(posedge clk) begin
        if (!rstN) begin
            modelAccum      = '0;
            modelAvg        = '0;
            modelFreqSample = '0;
            expStrobe       = 1'b0;
            expHigh         = 1'b0;
        end else begin
            expStrobe = sampleValid;
            if (sampleValid) begin
                for (int c = 0; c < 3; c++) begin
                    expDac[c] = dacSourceModel(shadowDac[c*4 +: 4], modelAccum, modelAvg);
                end
                expHigh         = absValue(modelAvg) > {2'b00, shadowFl[31:16]};
                modelAvg        = averagerModel(modelAvg, modelFreqSample, shadowFl[15:0]);
                modelFreqSample = (shadowCtrl[2:0] == ModeOqpsk) ? {freq, 10'b0}
                                                                 : {freqError, 10'b0};
                modelAccum      = magLoopModel(modelAccum, mag, shadowCtrl[11:8]);
            end
        end
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rstN) begin
            checkBit("dac0Strobe", expStrobe, dac0Strobe);
            checkBit("dac1Strobe", expStrobe, dac1Strobe);
            checkBit("dac2Strobe", expStrobe, dac2Strobe);
            checkBit("highFreqOffset", expHigh, highFreqOffset);
            if (expStrobe) begin
                checkSample("dac0Data", expDac[0], dac0Data);
                checkSample("dac1Data", expDac[1], dac1Data);
                checkSample("dac2Data", expDac[2], dac2Data);
            end
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        failRun("watchdog expired before the tests finished");
    end

    initial begin
        rstN        = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        sampleValid = 1'b0;
        iIn         = '0;
        qIn         = '0;
        freq        = '0;
        freqError   = '0;
        mag         = '0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkBit("bvalid", 1'b0, bvalid);
        checkBit("rvalid", 1'b0, rvalid);
        for (int a = 0; a < 16; a += 2) expectRead(regAddr_t'(a));

        // byte strobes, read-only status, unmapped offset
        writeReg(CtrlOffset, 32'hA5A5_5A5A, 4'hF, 1'b0);
        writeReg(FalseLockOffset, 32'h1234_5678, 4'b0101, 1'b0);
        writeReg(DacSelectOffset, 32'hFFFF_FFFF, 4'b0010, 1'b0);
        writeReg(StatusOffset, 32'hFFFF_FFFF, 4'hF, 1'b0);
        writeReg(4'h6, 32'hFFFF_FFFF, 4'hF, 1'b0);
        for (int a = 0; a < 16; a += 2) expectRead(regAddr_t'(a));

        // second write has to wait while the first response is held
        writeReg(FalseLockOffset, 32'h0000_00AA, 4'b0001, 1'b1);
        awaddr  = CtrlOffset;
        wdata   = 32'h0000_0003;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (awready || wready || !bvalid) begin
                failRun("a write was accepted while its predecessor's response was held");
            end
        end
        bready = 1'b1;
        @(negedge clk);
        while (bvalid) @(negedge clk);
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        shadowCtrl = 32'h0000_0003;
        expectRead(FalseLockOffset);
        expectRead(CtrlOffset);

        // every select on every channel, 6 is unlisted
        writeReg(CtrlOffset, 32'h0, 4'hF, 1'b0);
        writeReg(FalseLockOffset, 32'h0000_1000, 4'hF, 1'b0);
        for (int s = 0; s < 7; s++) begin
            writeReg(DacSelectOffset, {20'h0, 4'((s + 2) % 7), 4'((s + 1) % 7), 4'(s)},
                     4'hF, 1'b0);
            sendSamples(16, 1'b0, '0, 1'b0, '0);
        end

        // magnitude filter at two time constants
        writeReg(DacSelectOffset, 32'h0000_0444, 4'hF, 1'b0);
        for (int k = 0; k < 2; k++) begin
            writeReg(CtrlOffset, (k == 0) ? 32'h0000_0400 : 32'h0000_0900, 4'hF, 1'b0);
            sendSamples(32, 1'b1, 9'd300, 1'b0, '0);
            sendSamples(32, 1'b0, '0, 1'b0, '0);
        end

        // false lock, OQPSK then QPSK
        writeReg(DacSelectOffset, 32'h0000_0555, 4'hF, 1'b0);
        writeReg(FalseLockOffset, {16'd20000, 16'h2000}, 4'hF, 1'b0);
        for (int k = 0; k < 2; k++) begin
            writeReg(CtrlOffset, 32'((k == 0) ? ModeOqpsk : ModeQpsk), 4'hF, 1'b0);
            // average settles near +-40 << 10, about twice the threshold
            sendSamples(40, 1'b0, '0, 1'b1, 8'sd40);
            checkBit("highFreqOffset", 1'b1, highFreqOffset);
            expectRead(StatusOffset);
            // decays toward zero, well under the threshold
            sendSamples(40, 1'b0, '0, 1'b1, 8'sd0);
            checkBit("highFreqOffset", 1'b0, highFreqOffset);
            expectRead(StatusOffset);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* logic/demodMonitor.sv */
`timescale 1ns/1ps

module demodMonitor (
    input  logic                clk,
    input  logic                rstN,
    input  demodPkg::regAddr_t  awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  demodPkg::regData_t  wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  demodPkg::regAddr_t  araddr,
    input  logic                arvalid,
    output logic                arready,
    output demodPkg::regData_t  rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic                sampleValid,
    input  demodPkg::sample_t   iIn,
    input  demodPkg::sample_t   qIn,
    input  demodPkg::freqWord_t freq,
    input  demodPkg::freqWord_t freqError,
    input  demodPkg::mag_t      mag,
    output demodPkg::sample_t   dac0Data,
    output logic                dac0Strobe,
    output demodPkg::sample_t   dac1Data,
    output logic                dac1Strobe,
    output demodPkg::sample_t   dac2Data,
    output logic                dac2Strobe,
    output logic                highFreqOffset
);
    import demodPkg::*;

    demodMode_t  demodMode;
    logic [3:0]  amTC;
    logic [15:0] falseLockAlpha;
    logic [15:0] falseLockThreshold;
    dacSource_t  dac0Select;
    dacSource_t  dac1Select;
    dacSource_t  dac2Select;
    magAccum_t   magAccum;
    sample_t     averageFreq;

    demodRegs demodRegs_i (
        .clk, .rstN,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .highFreqOffset, .demodMode, .amTC, .falseLockAlpha, .falseLockThreshold,
        .dac0Select, .dac1Select, .dac2Select
    );

    magFilter magFilter_i (.clk, .rstN, .sampleValid, .mag, .amTC, .magAccum);

    falseLockDetector falseLockDetector_i (
        .clk, .rstN, .sampleValid, .demodMode, .freq, .freqError,
        .falseLockAlpha, .falseLockThreshold, .averageFreq, .highFreqOffset
    );

    // three identical monitor channels
    dacMux dac0Mux_i (
        .clk, .rstN, .sampleValid, .dacSelect(dac0Select), .iIn, .qIn, .freq, .freqError,
        .magAccum, .averageFreq, .dacData(dac0Data), .dacStrobe(dac0Strobe)
    );
    dacMux dac1Mux_i (
        .clk, .rstN, .sampleValid, .dacSelect(dac1Select), .iIn, .qIn, .freq, .freqError,
        .magAccum, .averageFreq, .dacData(dac1Data), .dacStrobe(dac1Strobe)
    );
    dacMux dac2Mux_i (
        .clk, .rstN, .sampleValid, .dacSelect(dac2Select), .iIn, .qIn, .freq, .freqError,
        .magAccum, .averageFreq, .dacData(dac2Data), .dacStrobe(dac2Strobe)
    );

endmodule

/* logic/dacMux.sv */
`timescale 1ns/1ps

module dacMux (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 sampleValid,
    input  demodPkg::dacSource_t dacSelect,
    input  demodPkg::sample_t    iIn,
    input  demodPkg::sample_t    qIn,
    input  demodPkg::freqWord_t  freq,
    input  demodPkg::freqWord_t  freqError,
    input  demodPkg::magAccum_t  magAccum,
    input  demodPkg::sample_t    averageFreq,
    output demodPkg::sample_t    dacData,
    output logic                 dacStrobe
);
    import demodPkg::*;

    sample_t dacNext;

    always_comb begin
        case (dacSelect)
            DacI:         dacNext = iIn;
            DacQ:         dacNext = qIn;
            DacFreq:      dacNext = sample_t'(freq) <<< FreqScaleShift;
            DacFreqError: dacNext = sample_t'(freqError) <<< FreqScaleShift;
            // offset binary to two's complement for the magnitude
            DacMag:       dacNext = {~magAccum[31], magAccum[30:14]};
            DacAvgFreq:   dacNext = averageFreq;
            default:      dacNext = iIn;
        endcase
    end

    always_ff @(posedge clk) begin
        dacData <= dacNext;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dacStrobe <= 1'b0;
        end else begin
            dacStrobe <= sampleValid;
        end
    end

endmodule

/* logic/falseLockDetector.sv */
`timescale 1ns/1ps

module falseLockDetector (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 sampleValid,
    input  demodPkg::demodMode_t demodMode,
    input  demodPkg::freqWord_t  freq,
    input  demodPkg::freqWord_t  freqError,
    input  logic [15:0]          falseLockAlpha,
    input  logic [15:0]          falseLockThreshold,
    output demodPkg::sample_t    averageFreq,
    output logic                 highFreqOffset
);
    import demodPkg::*;

    freqWord_t          freqSel;
    sample_t            freqSample;
    logic signed [17:0] alphaScaled;
    logic signed [17:0] oneMinusAlpha;
    logic signed [35:0] alphaProd;
    logic signed [35:0] decayProd;
    logic signed [35:0] alphaSum;
    logic [17:0]        absAverage;

    // OQPSK watches the frequency itself, other modes the loop error
    assign freqSel = (demodMode == ModeOqpsk) ? freq : freqError;

    assign alphaScaled   = {falseLockAlpha, 2'b00};
    assign oneMinusAlpha = 18'h20000 + ~{falseLockAlpha, 2'b00};

    // signed 18x18 products, one registered MAC stage
    assign alphaProd = freqSample * alphaScaled;
    assign decayProd = averageFreq * oneMinusAlpha;
    assign alphaSum  = alphaProd + decayProd;

    assign absAverage = averageFreq[17] ? 18'(-averageFreq) : 18'(averageFreq);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            freqSample     <= '0;
            averageFreq    <= '0;
            highFreqOffset <= 1'b0;
        end else if (sampleValid) begin
            freqSample  <= sample_t'(freqSel) <<< FreqScaleShift;
            averageFreq <= alphaSum[34:17];
            // compare uses the average from before this update
            highFreqOffset <= (absAverage > {2'b00, falseLockThreshold});
        end
    end

endmodule

/* logic/magFilter.sv */
`timescale 1ns/1ps

module magFilter (
    input  logic                clk,
    input  logic                rstN,
    input  logic                sampleValid,
    input  demodPkg::mag_t      mag,
    input  logic [3:0]          amTC,
    output demodPkg::magAccum_t magAccum
);
    import demodPkg::*;

    logic signed [9:0] magError;
    magAccum_t         errorExt;
    logic [4:0]        lagShift;

    // error against the top 10 bits of the accumulator
    assign magError = $signed({1'b0, mag}) - $signed(magAccum[31:22]);
    assign errorExt = {{22{magError[9]}}, magError};

    // larger time constant, smaller loop gain
    assign lagShift = 5'(MagShiftBase) - 5'(amTC);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            magAccum <= '0;
        end else if (sampleValid) begin
            // wraps modulo 2^32
            magAccum <= magAccum + (errorExt << lagShift);
        end
    end

endmodule

/* logic/demodRegs.sv */
`timescale 1ns/1ps

module demodRegs (
    input  logic                   clk,
    input  logic                   rstN,
    input  demodPkg::regAddr_t     awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  demodPkg::regData_t     wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  demodPkg::regAddr_t     araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output demodPkg::regData_t     rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  logic                   highFreqOffset,
    output demodPkg::demodMode_t   demodMode,
    output logic [3:0]             amTC,
    output logic [15:0]            falseLockAlpha,
    output logic [15:0]            falseLockThreshold,
    output demodPkg::dacSource_t   dac0Select,
    output demodPkg::dacSource_t   dac1Select,
    output demodPkg::dacSource_t   dac2Select
);
    import demodPkg::*;

    typedef enum logic {Idle, Resp} busState_t;

    busState_t wrState;
    busState_t rdState;
    regData_t  ctrlReg;
    regData_t  falseLockReg;
    regData_t  dacSelectReg;
    regData_t  readValue;
    logic      writeAccept;

    function automatic regData_t applyStrobe(regData_t oldValue, regData_t newValue,
                                             logic [3:0] strobe);
        regData_t result;
        result = oldValue;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                result[b*8 +: 8] = newValue[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // address and data are taken together, and only with no response pending
    assign writeAccept = (wrState == Idle) && awvalid && wvalid;
    assign awready     = writeAccept;
    assign wready      = writeAccept;
    assign bvalid      = (wrState == Resp);
    assign bresp       = 2'b00;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrState <= Idle;
        end else if (writeAccept) begin
            wrState <= Resp;
        end else if (wrState == Resp && bready) begin
            wrState <= Idle;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlReg      <= CtrlReset;
            falseLockReg <= FalseLockReset;
            dacSelectReg <= DacSelectReset;
        end else if (writeAccept) begin
            case (awaddr)
                CtrlOffset:      ctrlReg      <= applyStrobe(ctrlReg, wdata, wstrb);
                FalseLockOffset: falseLockReg <= applyStrobe(falseLockReg, wdata, wstrb);
                DacSelectOffset: dacSelectReg <= applyStrobe(dacSelectReg, wdata, wstrb);
                // status and unmapped offsets drop the write
                default: ;
            endcase
        end
    end

    always_comb begin
        case (araddr)
            CtrlOffset:      readValue = ctrlReg;
            FalseLockOffset: readValue = falseLockReg;
            DacSelectOffset: readValue = dacSelectReg;
            StatusOffset:    readValue = {31'b0, highFreqOffset};
            default:         readValue = '0;
        endcase
    end

    assign arready = (rdState == Idle);
    assign rvalid  = (rdState == Resp);
    assign rresp   = 2'b00;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdState <= Idle;
        end else if (arready && arvalid) begin
            rdState <= Resp;
        end else if (rvalid && rready) begin
            rdState <= Idle;
        end
    end

    // read data held until rready
    always_ff @(posedge clk) begin
        if (arready && arvalid) begin
            rdata <= readValue;
        end
    end

    assign demodMode          = demodMode_t'(ctrlReg[2:0]);
    assign amTC               = ctrlReg[11:8];
    assign falseLockAlpha     = falseLockReg[15:0];
    assign falseLockThreshold = falseLockReg[31:16];
    assign dac0Select         = dacSource_t'(dacSelectReg[3:0]);
    assign dac1Select         = dacSource_t'(dacSelectReg[7:4]);
    assign dac2Select         = dacSource_t'(dacSelectReg[11:8]);

endmodule

/* logic/demodPkg.sv */
package demodPkg;

    // sample path widths
    typedef logic signed [17:0] sample_t;
    typedef logic signed [7:0]  freqWord_t;
    typedef logic        [8:0]  mag_t;
    typedef logic        [31:0] magAccum_t;

    // register bus widths
    typedef logic [31:0] regData_t;
    typedef logic [3:0]  regAddr_t;

    typedef enum logic [2:0] {
        ModeAm    = 3'd0,
        ModeFm    = 3'd1,
        ModeBpsk  = 3'd2,
        ModeQpsk  = 3'd3,
        ModeOqpsk = 3'd4
    } demodMode_t;

    // monitor DAC sources, anything else falls back to I
    typedef enum logic [3:0] {
        DacI         = 4'd0,
        DacQ         = 4'd1,
        DacFreq      = 4'd2,
        DacFreqError = 4'd3,
        DacMag       = 4'd4,
        DacAvgFreq   = 4'd5
    } dacSource_t;

    // register byte offsets
    localparam regAddr_t CtrlOffset      = 4'h0;
    localparam regAddr_t FalseLockOffset = 4'h4;
    localparam regAddr_t DacSelectOffset = 4'h8;
    localparam regAddr_t StatusOffset    = 4'hC;

    localparam regData_t CtrlReset      = 32'h0000_0000;
    localparam regData_t FalseLockReset = 32'h0000_0000;
    localparam regData_t DacSelectReset = 32'h0000_0000;

    // lag shift is MagShiftBase - amTC, so the accumulator tracks mag * 2^22
    localparam int unsigned MagShiftBase   = 22;
    localparam int unsigned FreqScaleShift = 10;

endpackage
